// File: common/aqp_defs.svh
`ifndef AQP_DEFS_SVH
`define AQP_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// IO port addresses
////////////////////////////////////////////////////////////////////////////
`define AQP_IO_DAC          8'hEC   // Audio DAC, write only
`define AQP_IO_BANK0        8'hF0   // Bank register for $0000-$3FFF
`define AQP_IO_BANK1        8'hF1   // Bank register for $4000-$7FFF
`define AQP_IO_BANK2        8'hF2   // Bank register for $8000-$BFFF
`define AQP_IO_BANK3        8'hF3   // Bank register for $C000-$FFFF
`define AQP_IO_SYSCTRL      8'hFB   // Bit 0 disables bank and DAC ports
`define AQP_IO_CASSETTE     8'hFC
`define AQP_IO_PRINTER      8'hFE
`define AQP_IO_KEYB         8'hFF   // Row select on address bits 15:8

////////////////////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////////////////////

// Cartridge sits in a block of pages, RAM in the upper half of page space
`define AQP_PAGE_CART_FIRST 6'd16
`define AQP_CART_PAGES      6'd4

// 2 KB row $3800-$3FFF of an overlay bank, writable even if read-only
`define AQP_SYSRAM_ROW      3'd7

////////////////////////////////////////////////////////////////////////////
// Audio
////////////////////////////////////////////////////////////////////////////
`define AQP_MIX_W           13      // Mix and PWM counter width
`define AQP_BEEP_LEVEL      1023    // Cassette beep amplitude

`endif

// File: common/aqp_pkg.sv
`default_nettype none

`include "aqp_defs.svh"

package aqp_pkg;

    // One bank register as written at ports F0-F3
    typedef struct packed {
        logic       ro;         // Bit 7, blocks RAM writes
        logic       overlay;    // Bit 6
        logic [5:0] page;       // 16 KB page in the 1 MB space
    } bank_reg_t;

    // Index is address bits 15:14
    typedef bank_reg_t [3:0] bank_set_t;

    // Audio sample as fed to the PWM
    typedef logic [`AQP_MIX_W-1:0] mix_t;

endpackage

`default_nettype wire

// File: common/aqp_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Z80 bus cycle after strobe synchronization
interface aqp_bus_if;

    logic [15:0] addr;          // Straight from the bus
    logic  [7:0] wrdata;        // Latched during the write strobe
    logic        iorq;          // Active high IO request
    logic        bus_read;      // One clock per read cycle
    logic        bus_write;     // One clock per write cycle

    modport source (
        output addr,
        output wrdata,
        output iorq,
        output bus_read,
        output bus_write
    );

    modport sink (
        input  addr,
        input  wrdata,
        input  iorq,
        input  bus_read,
        input  bus_write
    );

endinterface

`default_nettype wire

// File: verilog/aqp_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none

module aqp_bus_sync (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] bus_a,
    input  logic  [7:0] bus_d_in,
    input  logic        bus_rd_n,
    input  logic        bus_wr_n,
    input  logic        bus_iorq_n,
    aqp_bus_if.source   bus
);

    logic [2:0] rd_n_sync;
    logic [2:0] wr_n_sync;
    logic [7:0] wrdata_r;

    // Strobes idle high, so the chains start at all ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_sync <= 3'b111;
            wr_n_sync <= 3'b111;
        end else begin
            rd_n_sync <= {rd_n_sync[1:0], bus_rd_n};
            wr_n_sync <= {wr_n_sync[1:0], bus_wr_n};
        end
    end

    // Follows the data bus for as long as the write strobe is low
    always_ff @(posedge clk) begin
        if (!bus_wr_n)
            wrdata_r <= bus_d_in;
    end

    // Falling edge seen between stage 2 and stage 1
    assign bus.bus_read  = rd_n_sync[2:1] == 2'b10;
    assign bus.bus_write = wr_n_sync[2:1] == 2'b10;

    assign bus.addr   = bus_a;
    assign bus.iorq   = !bus_iorq_n;   // Not synchronized, decoded with the address
    assign bus.wrdata = wrdata_r;

endmodule

`default_nettype wire

// File: verilog/aqp_mem_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "aqp_defs.svh"

module aqp_mem_map import aqp_pkg::*; (
    input  logic [15:0] bus_a,
    input  logic        bus_mreq_n,
    input  logic        bus_wr_n,
    input  bank_set_t   banks,
    output logic  [4:0] bus_ba,
    output logic        ram_ce_n,
    output logic        cart_ce_n,
    output logic        ram_we_n
);

    bank_reg_t bank;
    logic      sel_sysram;
    logic      sel_cart;
    logic      sel_ram;
    logic      wr_allowed;

    ////////////////////////////////////////////////////////////////////////////
    // Bank selection
    ////////////////////////////////////////////////////////////////////////////

    // One 16 KB window per value of the top two address bits
    assign bank   = banks[bus_a[15:14]];
    assign bus_ba = bank.page[4:0];     // Page bit 5 only picks RAM vs the rest

    ////////////////////////////////////////////////////////////////////////////
    // Chip enables
    ////////////////////////////////////////////////////////////////////////////

    // Overlay rows other than system RAM have no internal memory here,
    // so they fall through to whatever the page selects
    assign sel_sysram = bank.overlay && bus_a[13:11] == `AQP_SYSRAM_ROW;

    assign sel_cart = !bus_mreq_n &&
                      bank.page >= `AQP_PAGE_CART_FIRST &&
                      bank.page <  `AQP_PAGE_CART_FIRST + `AQP_CART_PAGES;   // Pages 16-19

    assign sel_ram = !bus_mreq_n && bank.page[5];   // Pages 32-63

    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;

    ////////////////////////////////////////////////////////////////////////////
    // Write enable with read-only protection
    ////////////////////////////////////////////////////////////////////////////

    // System RAM stays writable in a read-only overlay bank
    assign wr_allowed = !bank.ro || sel_sysram;

    assign ram_we_n = !(sel_ram && !bus_wr_n && wr_allowed);

endmodule

`default_nettype wire

// File: verilog/aqp_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "aqp_defs.svh"

module aqp_io_regs import aqp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    aqp_bus_if.sink     bus,
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    output bank_set_t   banks,
    output logic  [7:0] dac,
    output logic        cassette_out,
    output logic        printer_out,
    output logic  [7:0] rddata,
    output logic        rd_hit
);

    logic [7:0] port;
    logic       dis_regs;         // FB bit 0

    logic       sel_dac;
    logic [3:0] sel_bank;
    logic       sel_sysctrl;
    logic       sel_cassette;
    logic       sel_printer;
    logic       sel_keyb;

    logic [2:0] cassette_in_sync;
    logic [2:0] printer_in_sync;
    logic [7:0] keyb_data;

    ////////////////////////////////////////////////////////////////////////////
    // Port decoding
    ////////////////////////////////////////////////////////////////////////////
    assign port = bus.addr[7:0];

    // Bank and DAC ports vanish while the disable bit is set
    assign sel_dac     = bus.iorq && !dis_regs && port == `AQP_IO_DAC;
    assign sel_bank[0] = bus.iorq && !dis_regs && port == `AQP_IO_BANK0;
    assign sel_bank[1] = bus.iorq && !dis_regs && port == `AQP_IO_BANK1;
    assign sel_bank[2] = bus.iorq && !dis_regs && port == `AQP_IO_BANK2;
    assign sel_bank[3] = bus.iorq && !dis_regs && port == `AQP_IO_BANK3;

    assign sel_sysctrl  = bus.iorq && port == `AQP_IO_SYSCTRL;
    assign sel_cassette = bus.iorq && port == `AQP_IO_CASSETTE;
    assign sel_printer  = bus.iorq && port == `AQP_IO_PRINTER;
    assign sel_keyb     = bus.iorq && port == `AQP_IO_KEYB;     // Read only

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            banks        <= '0;     // All windows on page 0
            dac          <= 8'h00;
            dis_regs     <= 1'b0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus.bus_write) begin
            if (sel_dac)
                dac <= bus.wrdata;
            for (int i = 0; i < 4; i++) begin
                if (sel_bank[i])
                    banks[i] <= bank_reg_t'(bus.wrdata);
            end
            if (sel_sysctrl)
                dis_regs <= bus.wrdata[0];      // Upper bits not stored
            if (sel_cassette)
                cassette_out <= bus.wrdata[0];
            if (sel_printer)
                printer_out <= bus.wrdata[0];
        end
    end

    // Asynchronous inputs from the board
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_in_sync <= 3'b000;
            printer_in_sync  <= 3'b000;
        end else begin
            cassette_in_sync <= {cassette_in_sync[1:0], cassette_in};
            printer_in_sync  <= {printer_in_sync[1:0], printer_in};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard matrix
    ////////////////////////////////////////////////////////////////////////////

    // A low address bit in 15:8 selects its row, keys are active low
    always_comb begin
        keyb_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!bus.addr[8 + row])
                keyb_data = keyb_data & keys[8*row +: 8];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rddata = 8'h00;
        for (int i = 0; i < 4; i++) begin
            if (sel_bank[i])
                rddata = banks[i];
        end
        if (sel_sysctrl)
            rddata = {7'b0, dis_regs};
        if (sel_cassette)
            rddata = {7'b0, !cassette_in_sync[2]};   // Inverted line
        if (sel_printer)
            rddata = {7'b0, printer_in_sync[2]};
        if (sel_keyb)
            rddata = keyb_data;
    end

    // DAC is write only and never drives the bus
    assign rd_hit = |sel_bank || sel_sysctrl || sel_cassette || sel_printer || sel_keyb;

endmodule

`default_nettype wire

// File: audio/aqp_audio_pwm.sv
`timescale 1ns/1ps
`default_nettype none

`include "aqp_defs.svh"

module aqp_audio_pwm import aqp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] dac,
    input  logic       cassette_out,
    output logic       audio
);

    mix_t beep;
    mix_t mix;
    mix_t sample;
    mix_t level;                // Compare value for the current cycle
    mix_t counter;

    ////////////////////////////////////////////////////////////////////////////
    // Mixer
    ////////////////////////////////////////////////////////////////////////////
    assign beep = cassette_out ? mix_t'(`AQP_BEEP_LEVEL) : '0;
    assign mix  = mix_t'({dac, 4'b0000}) + beep;   // DAC x16, peak 5103

    ////////////////////////////////////////////////////////////////////////////
    // PWM
    ////////////////////////////////////////////////////////////////////////////

    // New sample takes effect from count zero, so a whole period uses one value
    assign level = (counter == '0) ? mix : sample;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            counter <= '0;
            sample  <= '0;
            audio   <= 1'b0;
        end else begin
            counter <= counter + 1'b1;         // Wraps every 8192 cycles
            if (counter == '0)
                sample <= mix;
            audio <= counter < level;
        end
    end

endmodule

`default_nettype wire

// File: verilog/aqp_top.sv
`timescale 1ns/1ps
`default_nettype none

module aqp_top import aqp_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Z80 bus
    input  logic [15:0] bus_a,
    input  logic  [7:0] bus_d_in,
    output logic  [7:0] bus_d_out,
    output logic        bus_d_oe,       // Core drives the data bus
    input  logic        bus_rd_n,
    input  logic        bus_wr_n,
    input  logic        bus_mreq_n,
    input  logic        bus_iorq_n,

    // External memory
    output logic  [4:0] bus_ba,
    output logic        ram_ce_n,
    output logic        cart_ce_n,
    output logic        ram_we_n,

    // Keyboard matrix, one byte per row
    input  logic [63:0] keys,

    // Cassette, printer and audio
    output logic        cassette_out,
    input  logic        cassette_in,
    output logic        printer_out,
    input  logic        printer_in,
    output logic        audio
);

    bank_set_t  banks;
    logic [7:0] dac;
    logic [7:0] rddata;
    logic       rd_hit;

    aqp_bus_if u_bus ();

    aqp_bus_sync u_bus_sync (
        .clk        (clk),
        .reset      (reset),
        .bus_a      (bus_a),
        .bus_d_in   (bus_d_in),
        .bus_rd_n   (bus_rd_n),
        .bus_wr_n   (bus_wr_n),
        .bus_iorq_n (bus_iorq_n),
        .bus        (u_bus.source)
    );

    aqp_io_regs u_io_regs (
        .clk          (clk),
        .reset        (reset),
        .bus          (u_bus.sink),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .banks        (banks),
        .dac          (dac),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .rddata       (rddata),
        .rd_hit       (rd_hit)
    );

    aqp_mem_map u_mem_map (
        .bus_a      (bus_a),
        .bus_mreq_n (bus_mreq_n),
        .bus_wr_n   (bus_wr_n),
        .banks      (banks),
        .bus_ba     (bus_ba),
        .ram_ce_n   (ram_ce_n),
        .cart_ce_n  (cart_ce_n),
        .ram_we_n   (ram_we_n)
    );

    aqp_audio_pwm u_audio (
        .clk          (clk),
        .reset        (reset),
        .dac          (dac),
        .cassette_out (cassette_out),
        .audio        (audio)
    );

    assign bus_d_out = rddata;
    assign bus_d_oe  = !bus_rd_n && rd_hit;

endmodule

`default_nettype wire

// File: tests/tb_aqp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aqp_defs.svh"

module tb_aqp_top;

    localparam int PERIOD_CYCLES  = 1 << `AQP_MIX_W;   // One PWM period
    localparam int TIMEOUT_CYCLES = 200000;

    logic        clk;
    logic        reset;
    logic [15:0] bus_a;
    logic  [7:0] bus_d_in;
    logic  [7:0] bus_d_out;
    logic        bus_d_oe;
    logic        bus_rd_n;
    logic        bus_wr_n;
    logic        bus_mreq_n;
    logic        bus_iorq_n;
    logic  [4:0] bus_ba;
    logic        ram_ce_n;
    logic        cart_ce_n;
    logic        ram_we_n;
    logic [63:0] keys;
    logic        cassette_out;
    logic        cassette_in;
    logic        printer_out;
    logic        printer_in;
    logic        audio;

    integer      seed;
    int          errors;
    int          checks;

    // Reference model of the register file
    logic  [7:0] model_bank [0:3];
    logic        model_dis;
    logic  [7:0] model_dac;
    logic        model_cas_out;
    logic        model_prn_out;

    aqp_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .bus_a        (bus_a),
        .bus_d_in     (bus_d_in),
        .bus_d_out    (bus_d_out),
        .bus_d_oe     (bus_d_oe),
        .bus_rd_n     (bus_rd_n),
        .bus_wr_n     (bus_wr_n),
        .bus_mreq_n   (bus_mreq_n),
        .bus_iorq_n   (bus_iorq_n),
        .bus_ba       (bus_ba),
        .ram_ce_n     (ram_ce_n),
        .cart_ce_n    (cart_ce_n),
        .ram_we_n     (ram_we_n),
        .keys         (keys),
        .cassette_out (cassette_out),
        .cassette_in  (cassette_in),
        .printer_out  (printer_out),
        .printer_in   (printer_in),
        .audio        (audio)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        for (int n = 0; n < TIMEOUT_CYCLES; n++)
            @(posedge clk);
        $display("Timeout: the test sequence did not complete in time");
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [7:0] key_rows_and(input logic [63:0] k, input logic [7:0] row_n);
        logic [7:0] result;
        result = 8'hFF;
        for (int b = 0; b < 64; b++) begin
            if (!row_n[b / 8] && !k[b])
                result[b % 8] = 1'b0;   // Pressed key in a selected row
        end
        return result;
    endfunction

    task automatic update_model(input logic [7:0] port, input logic [7:0] data);
        case (port)
            `AQP_IO_BANK0, `AQP_IO_BANK1, `AQP_IO_BANK2, `AQP_IO_BANK3: begin
                if (!model_dis)
                    model_bank[port[1:0]] = data;
            end
            `AQP_IO_DAC: begin
                if (!model_dis)
                    model_dac = data;
            end
            `AQP_IO_SYSCTRL:  model_dis     = data[0];
            `AQP_IO_CASSETTE: model_cas_out = data[0];
            `AQP_IO_PRINTER:  model_prn_out = data[0];
            default: ;
        endcase
    endtask

    // Returns whether the port drives the bus
    function automatic logic predict_read(input logic [15:0] addr, output logic [7:0] data);
        logic [7:0] port;
        logic       hit;
        port = addr[7:0];
        hit  = 1'b1;
        data = 8'h00;
        if (!model_dis && port >= `AQP_IO_BANK0 && port <= `AQP_IO_BANK3)
            data = model_bank[port[1:0]];
        else if (port == `AQP_IO_SYSCTRL)
            data = {7'd0, model_dis};
        else if (port == `AQP_IO_CASSETTE)
            data = {7'd0, ~cassette_in};
        else if (port == `AQP_IO_PRINTER)
            data = {7'd0, printer_in};
        else if (port == `AQP_IO_KEYB)
            data = key_rows_and(keys, addr[15:8]);
        else
            hit = 1'b0;             // DAC and unused ports
        return hit;
    endfunction

    task automatic predict_mem(input logic [15:0] addr, input logic mreq_n, input logic wr_n,
                               output logic [4:0] ba, output logic ram_n,
                               output logic cart_n, output logic we_n);
        logic [7:0] b;
        logic [5:0] page;
        logic       ram;
        logic       writable;
        b        = model_bank[addr[15:14]];
        page     = b[5:0];
        ba       = page[4:0];
        ram      = !mreq_n && page >= 6'd32;
        cart_n   = !(!mreq_n && page >= `AQP_PAGE_CART_FIRST &&
                     page <= `AQP_PAGE_CART_FIRST + 6'd3);
        ram_n    = !ram;
        writable = !b[7] || (b[6] && addr[13:11] == `AQP_SYSRAM_ROW);
        we_n     = !(ram && !wr_n && writable);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus drivers and checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(posedge clk);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic write_port(input logic [7:0] port, input logic [7:0] data);
        logic [31:0] r;
        r = rand_word();
        bus_a      <= {r[7:0], port};
        bus_d_in   <= data;
        bus_iorq_n <= 1'b0;
        bus_wr_n   <= 1'b0;
        wait_cycles(6);
        bus_wr_n   <= 1'b1;
        bus_iorq_n <= 1'b1;
        wait_cycles(4);
        update_model(port, data);
    endtask

    task automatic read_and_compare(input logic [15:0] addr);
        logic [7:0] exp_data;
        logic       exp_oe;
        bus_a      <= addr;
        bus_iorq_n <= 1'b0;
        bus_rd_n   <= 1'b0;
        wait_cycles(5);
        @(negedge clk);
        exp_oe = predict_read(addr, exp_data);
        compare("bus_d_oe", 32'(exp_oe), 32'(bus_d_oe));
        if (exp_oe)
            compare("bus_d_out", 32'(exp_data), 32'(bus_d_out));
        compare("cassette_out", 32'(model_cas_out), 32'(cassette_out));
        compare("printer_out", 32'(model_prn_out), 32'(printer_out));
        @(posedge clk);
        bus_rd_n   <= 1'b1;
        bus_iorq_n <= 1'b1;
        wait_cycles(4);
    endtask

    task automatic drive_mem(input logic [15:0] addr, input logic mreq_n, input logic wr_n);
        logic [4:0] exp_ba;
        logic       exp_ram_n;
        logic       exp_cart_n;
        logic       exp_we_n;
        bus_a      <= addr;
        bus_mreq_n <= mreq_n;
        bus_wr_n   <= wr_n;
        @(negedge clk);
        predict_mem(addr, mreq_n, wr_n, exp_ba, exp_ram_n, exp_cart_n, exp_we_n);
        compare("bus_ba", 32'(exp_ba), 32'(bus_ba));
        compare("ram_ce_n", 32'(exp_ram_n), 32'(ram_ce_n));
        compare("cart_ce_n", 32'(exp_cart_n), 32'(cart_ce_n));
        compare("ram_we_n", 32'(exp_we_n), 32'(ram_we_n));
        @(posedge clk);
        bus_mreq_n <= 1'b1;
        bus_wr_n   <= 1'b1;
        wait_cycles(3);             // Write strobe chain back to idle
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_state();
        logic [31:0] r;
        for (int b = 0; b < 4; b++)
            read_and_compare({8'h00, `AQP_IO_BANK0 + 8'(b)});
        read_and_compare({8'h00, `AQP_IO_SYSCTRL});
        @(negedge clk);
        compare("audio", 32'(1'b0), 32'(audio));
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            r = rand_word();
            drive_mem(r[15:0], 1'b0, r[16]);    // All windows still on page 0
        end
    endtask

    task automatic register_readback();
        logic [31:0] r;
        logic  [7:0] port;
        for (int i = 0; i < 40; i++) begin
            r = rand_word();
            case (r[2:0])
                3'd4:       port = `AQP_IO_SYSCTRL;
                3'd5:       port = `AQP_IO_CASSETTE;
                3'd6, 3'd7: port = `AQP_IO_PRINTER;
                default:    port = `AQP_IO_BANK0 + {6'd0, r[1:0]};
            endcase
            write_port(port, r[15:8]);
            read_and_compare({r[23:16], port});
        end
        // Write-only DAC and ports below $80
        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            read_and_compare({r[15:8], r[0] ? `AQP_IO_DAC : {1'b0, r[7:1]}});
        end
        write_port(`AQP_IO_SYSCTRL, 8'h00);
    endtask

    task automatic memory_decode();
        logic [31:0] r;
        logic [15:0] addr;
        for (int round = 0; round < 30; round++) begin
            for (int b = 0; b < 4; b++) begin
                r = rand_word();
                write_port(`AQP_IO_BANK0 + 8'(b), r[7:0]);
            end
            for (int k = 0; k < 8; k++) begin
                r    = rand_word();
                addr = r[15:0];
                if (r[16])
                    addr[13:11] = `AQP_SYSRAM_ROW;   // Hit the system RAM row often
                drive_mem(addr, r[18:17] == 2'b00, r[19]);
            end
        end
    endtask

    task automatic register_disable();
        logic [31:0] r;
        write_port(`AQP_IO_SYSCTRL, 8'h01);
        for (int b = 0; b < 4; b++) begin
            r = rand_word();
            write_port(`AQP_IO_BANK0 + 8'(b), r[7:0]);
            read_and_compare({r[15:8], `AQP_IO_BANK0 + 8'(b)});
        end
        r = rand_word();
        write_port(`AQP_IO_DAC, r[7:0] | 8'h01);   // Ignored while disabled
        write_port(`AQP_IO_SYSCTRL, 8'h00);
        for (int b = 0; b < 4; b++)
            read_and_compare({8'h00, `AQP_IO_BANK0 + 8'(b)});
    endtask

    task automatic keyboard_rows();
        logic [31:0] r;
        logic  [7:0] row_n;
        for (int i = 0; i < 20; i++) begin
            r     = rand_word();
            row_n = r[8] ? ~(8'h01 << r[11:9]) : r[7:0];
            keys <= {rand_word(), rand_word()} | {rand_word(), rand_word()};
            read_and_compare({row_n, `AQP_IO_KEYB});
        end
    endtask

    task automatic cassette_printer();
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            r = rand_word();
            cassette_in <= r[0];
            printer_in  <= r[1];
            wait_cycles(4);         // Input synchronizers
            read_and_compare({8'h00, `AQP_IO_CASSETTE});
            read_and_compare({8'h00, `AQP_IO_PRINTER});
        end
    endtask

    task automatic audio_pwm();
        logic [31:0] r;
        int          expected;
        int          high;
        for (int i = 0; i < 4; i++) begin
            // First pass runs on the DAC and beep left by the earlier sequences
            if (i > 0) begin
                r = rand_word();
                write_port(`AQP_IO_DAC, r[7:0]);
                write_port(`AQP_IO_CASSETTE, {7'd0, r[8]});
            end
            wait_cycles(2 * PERIOD_CYCLES);
            expected = int'(model_dac) * 16 + (model_cas_out ? `AQP_BEEP_LEVEL : 0);
            high = 0;
            for (int n = 0; n < PERIOD_CYCLES; n++) begin
                @(negedge clk);
                if (audio)
                    high = high + 1;
            end
            compare("audio high cycles", 32'(expected), 32'(high));
            @(posedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed          = 32'hd7deb4c2;
        errors        = 0;
        checks        = 0;
        model_dis     = 1'b0;
        model_dac     = 8'h00;
        model_cas_out = 1'b0;
        model_prn_out = 1'b0;
        for (int b = 0; b < 4; b++)
            model_bank[b] = 8'h00;

        reset       <= 1'b1;
        bus_a       <= 16'h0000;
        bus_d_in    <= 8'h00;
        bus_rd_n    <= 1'b1;
        bus_wr_n    <= 1'b1;
        bus_mreq_n  <= 1'b1;
        bus_iorq_n  <= 1'b1;
        keys        <= '1;          // No key pressed
        cassette_in <= 1'b0;
        printer_in  <= 1'b0;
        wait_cycles(10);
        reset <= 1'b0;
        wait_cycles(2);

        reset_state();
        register_readback();
        memory_decode();
        register_disable();
        keyboard_rows();
        cassette_printer();
        audio_pwm();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: aqp_core.f
+incdir+common
common/aqp_pkg.sv
common/aqp_bus_if.sv
verilog/aqp_bus_sync.sv
verilog/aqp_mem_map.sv
verilog/aqp_io_regs.sv
audio/aqp_audio_pwm.sv
verilog/aqp_top.sv
tests/tb_aqp_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_aqp_top \
    -f aqp_core.f \
    --Mdir obj_dir

./obj_dir/Vtb_aqp_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim.sh: failures found in sim.log"
    exit 1
fi

echo "run_sim.sh: no failures found in sim.log"
